// File: hw/hexio_macros.svh
// sizes of the memory image and of both credit pools
// HEXIO_DEPTH must equal 2**HEXIO_ADDR_W, HEXIO_RX_CREDITS a power of two
`ifndef HEXIO_MACROS_SVH
`define HEXIO_MACROS_SVH

// ***********************************************************
// image geometry
// ***********************************************************
`define HEXIO_WORD_W      32                  // bits per memory word
`define HEXIO_NIBBLES     (`HEXIO_WORD_W / 4) // hex digits per word, msd first
`define HEXIO_DEPTH       16                  // words in the image
`define HEXIO_ADDR_W      4                   // word address bits

// ***********************************************************
// flow control
// ***********************************************************
// receive buffer entries; the sender starts with this many credits
`define HEXIO_RX_CREDITS  4
// credits held by the dump side after reset
`define HEXIO_TX_CREDITS  4

`endif

// File: hw/hexio_chars_pkg.sv
// character codes of the hex text format
// digits are plain ascii, framing bytes follow the file-transfer convention
`default_nettype none

package hexio_chars_pkg;

  typedef logic [7:0] char_t;    // one byte of either stream
  typedef logic [3:0] nibble_t;  // one hex digit

  // framing bytes of a dumped file
  typedef enum logic [7:0] {
    SOH = 8'h01,  // start of header
    SOT = 8'h02,  // start of text, also arms the loader
    EOT = 8'h03,  // end of header
    EOF = 8'h04,  // closes the file
    LF  = 8'h0A,
    CR  = 8'h0D
  } ctrl_char_e;

  // digit ranges
  localparam char_t CHAR_0     = 8'h30;
  localparam char_t CHAR_9     = 8'h39;
  localparam char_t CHAR_UP_A  = 8'h41;
  localparam char_t CHAR_UP_F  = 8'h46;
  localparam char_t CHAR_LOW_A = 8'h61;
  localparam char_t CHAR_LOW_F = 8'h66;

endpackage

`default_nettype wire

// File: hw/hexio_ctrl_pkg.sv
// state encodings of the loader and of the dump sequencer
`default_nettype none

package hexio_ctrl_pkg;

  // image_store mode
  typedef enum logic [1:0] {
    IDLE,      // accepts commands
    WAIT_SOT,  // load armed, text not started
    LOAD,      // words go to memory
    DUMP       // formatter owns the read port
  } store_state_e;

  // dump_formatter sequence
  typedef enum logic [2:0] {
    HEADER,    // SOH EOT SOT
    ROW,       // hex digits of one word
    LINE_END,  // CR LF
    TRAILER,   // EOF
    DONE       // resting state between dumps
  } dump_state_e;

endpackage

`default_nettype wire

// File: hw/hex_char_decode.sv
// hex text decoder; one character leaves the buffer per cycle, one credit each
// only SOT and hex digits (either case) have an effect, the rest is dropped
`timescale 1ns/1ps
`include "hexio_macros.svh"
`default_nettype none

module hex_char_decode (
  input  wire                         clk_sys,
  input  wire                         rst_clk,
  input  wire hexio_chars_pkg::char_t rx_char_i,
  input  wire                         rx_valid_i,
  output logic                        rx_credit_o,
  output logic                        sot_seen_o,
  output logic                        word_valid_o,
  output logic [`HEXIO_WORD_W-1:0]    word_o
);

  import hexio_chars_pkg::*;

  localparam int PTR_W = $clog2(`HEXIO_RX_CREDITS);
  localparam int CNT_W = $clog2(`HEXIO_RX_CREDITS + 1);
  localparam int NIB_W = $clog2(`HEXIO_NIBBLES);

  char_t                    fifo_mem [`HEXIO_RX_CREDITS];
  logic [PTR_W-1:0]         wr_ptr;
  logic [PTR_W-1:0]         rd_ptr;
  logic [CNT_W-1:0]         fill_cnt;
  logic                     push;
  logic                     pop;
  char_t                    head_char;
  logic [4:0]               head_val;  // {not_hex, value} of head_char
  logic                     head_hex;
  nibble_t                  head_nib;
  logic [NIB_W-1:0]         nib_cnt;   // digits packed since last word or SOT
  logic [`HEXIO_WORD_W-1:0] word_q;

  // returns {not_hex, value}
  function automatic logic [4:0] hex_value(input char_t c);
    logic [4:0] v;
    if ((c >= CHAR_0) && (c <= CHAR_9))
      v = {1'b0, c[3:0]};
    else if (((c >= CHAR_UP_A) && (c <= CHAR_UP_F)) ||
             ((c >= CHAR_LOW_A) && (c <= CHAR_LOW_F)))
      v = {1'b0, c[3:0] + 4'h9};   // a/A = x1 -> 10
    else
      v = 5'b1_0000;
    return v;
  endfunction

  // ***********************************************************
  // character buffer
  // ***********************************************************
  assign push      = rx_valid_i && (fill_cnt != CNT_W'(`HEXIO_RX_CREDITS)); // full = sender fault
  assign pop       = (fill_cnt != '0);
  assign head_char = fifo_mem[rd_ptr];
  assign rx_credit_o = pop;   // slot freed, credit back

  always_ff @(posedge clk_sys)
  begin
    if (push)
      fifo_mem[wr_ptr] <= rx_char_i;
  end

  always_ff @(posedge clk_sys)
  begin
    if (rst_clk)
    begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fill_cnt <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   fill_cnt <= fill_cnt + 1'b1;
        2'b01:   fill_cnt <= fill_cnt - 1'b1;
        default: fill_cnt <= fill_cnt;
      endcase
    end
  end

  // ***********************************************************
  // classify and pack
  // ***********************************************************
  assign head_val     = hex_value(head_char);
  assign head_hex     = ~head_val[4];
  assign head_nib     = head_val[3:0];
  assign sot_seen_o   = pop && (head_char == SOT);
  assign word_o       = {word_q[`HEXIO_WORD_W-5:0], head_nib};   // new digit lands lsb
  assign word_valid_o = pop && head_hex && (nib_cnt == NIB_W'(`HEXIO_NIBBLES - 1));

  always_ff @(posedge clk_sys)
  begin
    if (rst_clk)
      nib_cnt <= '0;
    else if (sot_seen_o)
      nib_cnt <= '0;                 // realign on start of text
    else if (pop && head_hex)
      nib_cnt <= (nib_cnt == NIB_W'(`HEXIO_NIBBLES - 1)) ? '0 : nib_cnt + 1'b1;
  end

  // shift register, older digits move up
  always_ff @(posedge clk_sys)
  begin
    if (pop && head_hex)
      word_q <= word_o;
  end

endmodule

`default_nettype wire

// File: hw/image_store.sv
// image memory with the load/dump mode FSM; words are taken only in LOAD
// read data appears one cycle after rd_addr_i, writes land on the next edge
`timescale 1ns/1ps
`include "hexio_macros.svh"
`default_nettype none

module image_store (
  input  wire                       clk_sys,
  input  wire                       rst_clk,
  input  wire                       load_start_i,
  input  wire                       dump_start_i,
  input  wire                       sot_seen_i,
  input  wire                       word_valid_i,
  input  wire [`HEXIO_WORD_W-1:0]   word_i,
  input  wire [`HEXIO_ADDR_W-1:0]   rd_addr_i,
  input  wire                       dump_done_i,
  output logic [`HEXIO_WORD_W-1:0]  rd_word_o,
  output logic                      dump_go_o,
  output logic                      busy_o,
  output logic                      load_done_o
);

  import hexio_ctrl_pkg::*;

  localparam int ADDR_W = `HEXIO_ADDR_W;

  store_state_e              state_q;
  logic [`HEXIO_WORD_W-1:0]  mem [`HEXIO_DEPTH];
  logic [ADDR_W-1:0]         wr_addr;     // next word slot
  logic                      wr_en;
  logic                      last_word;

  assign wr_en     = (state_q == LOAD) && word_valid_i;  // stray words dropped
  assign last_word = (wr_addr == ADDR_W'(`HEXIO_DEPTH - 1));
  assign busy_o    = (state_q != IDLE);

  // ***********************************************************
  // mode FSM
  // ***********************************************************
  always_ff @(posedge clk_sys)
  begin
    if (rst_clk)
    begin
      state_q     <= IDLE;
      wr_addr     <= '0;
      dump_go_o   <= 1'b0;
      load_done_o <= 1'b0;
    end
    else
    begin
      dump_go_o   <= 1'b0;   // single cycle pulses
      load_done_o <= 1'b0;
      case (state_q)
        IDLE:
          if (load_start_i)              // load beats dump
            state_q <= WAIT_SOT;
          else if (dump_start_i)
          begin
            state_q   <= DUMP;
            dump_go_o <= 1'b1;
          end
        WAIT_SOT:
          if (sot_seen_i)
          begin
            state_q <= LOAD;
            wr_addr <= '0;               // image starts at word 0
          end
        LOAD:
          if (word_valid_i)
          begin
            if (last_word)
            begin
              state_q     <= IDLE;
              load_done_o <= 1'b1;
            end
            else
              wr_addr <= wr_addr + 1'b1;
          end
        DUMP:
          if (dump_done_i)
            state_q <= IDLE;
        default:
          state_q <= IDLE;
      endcase
    end
  end

  // ***********************************************************
  // memory, one write and one registered read port
  // ***********************************************************
  always_ff @(posedge clk_sys)
  begin
    if (wr_en)
      mem[wr_addr] <= word_i;
    rd_word_o <= mem[rd_addr_i];   // free running read
  end

endmodule

`default_nettype wire

// File: hw/dump_formatter.sv
// sends the image as SOH EOT SOT, one hex line per word, EOF
// one character per cycle while credits last, the sequence stalls at zero credits
`timescale 1ns/1ps
`include "hexio_macros.svh"
`default_nettype none

module dump_formatter (
  input  wire                       clk_sys,
  input  wire                       rst_clk,
  input  wire                       dump_go_i,
  input  wire [`HEXIO_WORD_W-1:0]   rd_word_i,
  input  wire                       tx_credit_i,
  output logic [`HEXIO_ADDR_W-1:0]  rd_addr_o,
  output hexio_chars_pkg::char_t    tx_char_o,
  output logic                      tx_valid_o,
  output logic                      dump_done_o
);

  import hexio_chars_pkg::*;
  import hexio_ctrl_pkg::*;

  localparam int NIB_W  = $clog2(`HEXIO_NIBBLES);
  localparam int CRED_W = $clog2(`HEXIO_TX_CREDITS + 1);
  localparam int ADDR_W = `HEXIO_ADDR_W;

  dump_state_e        state_q;
  logic [1:0]         hdr_idx;   // SOH, EOT, SOT
  logic [NIB_W-1:0]   nib_idx;   // digit in ROW, CR/LF in LINE_END
  logic               last_row;
  logic [CRED_W-1:0]  credits;
  nibble_t            cur_nib;

  // upper case only
  function automatic char_t hex_char(input nibble_t n);
    char_t c;
    if (n < 4'd10)
      c = CHAR_0 + char_t'(n);
    else
      c = CHAR_UP_A + char_t'(n - 4'd10);
    return c;
  endfunction

  assign tx_valid_o = (state_q != DONE) && (credits != '0);
  assign cur_nib    = rd_word_i[`HEXIO_WORD_W - 4 - 4*nib_idx +: 4];  // msd first

  always_comb
  begin
    case (state_q)
      HEADER:
        case (hdr_idx)
          2'd0:    tx_char_o = SOH;
          2'd1:    tx_char_o = EOT;
          default: tx_char_o = SOT;
        endcase
      ROW:      tx_char_o = hex_char(cur_nib);
      LINE_END: tx_char_o = nib_idx[0] ? LF : CR;
      TRAILER:  tx_char_o = EOF;
      default:  tx_char_o = '0;
    endcase
  end

  // ***********************************************************
  // transmit credits, one spent per valid cycle
  // ***********************************************************
  always_ff @(posedge clk_sys)
  begin
    if (rst_clk)
      credits <= CRED_W'(`HEXIO_TX_CREDITS);
    else
      case ({tx_valid_o, tx_credit_i})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;     // none or spend and return together
      endcase
  end

  // ***********************************************************
  // sequencer, advances only on a sent character
  // ***********************************************************
  always_ff @(posedge clk_sys)
  begin
    if (rst_clk)
    begin
      state_q     <= DONE;
      hdr_idx     <= '0;
      nib_idx     <= '0;
      rd_addr_o   <= '0;
      last_row    <= 1'b0;
      dump_done_o <= 1'b0;
    end
    else
    begin
      dump_done_o <= 1'b0;
      case (state_q)
        DONE:
          if (dump_go_i)
          begin
            state_q   <= HEADER;
            hdr_idx   <= '0;
            nib_idx   <= '0;
            rd_addr_o <= '0;       // row 0 fetched under the header
            last_row  <= 1'b0;
          end
        HEADER:
          if (tx_valid_o)
          begin
            if (hdr_idx == 2'd2)
              state_q <= ROW;
            hdr_idx <= hdr_idx + 1'b1;
          end
        ROW:
          if (tx_valid_o)
          begin
            if (nib_idx == NIB_W'(`HEXIO_NIBBLES - 1))
            begin
              state_q <= LINE_END;
              nib_idx <= '0;
              if (rd_addr_o == ADDR_W'(`HEXIO_DEPTH - 1))
                last_row <= 1'b1;
              else
                rd_addr_o <= rd_addr_o + 1'b1;   // next word read during CR LF
            end
            else
              nib_idx <= nib_idx + 1'b1;
          end
        LINE_END:
          if (tx_valid_o)
          begin
            if (nib_idx[0])                    // LF just went out
            begin
              nib_idx <= '0;
              state_q <= last_row ? TRAILER : ROW;
            end
            else
              nib_idx <= nib_idx + 1'b1;
          end
        TRAILER:
          if (tx_valid_o)
          begin
            state_q     <= DONE;
            dump_done_o <= 1'b1;               // EOF sent
          end
        default:
          state_q <= DONE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/hexio_top.sv
// hex image loader and dumper, single clock, credit flow on both streams
`timescale 1ns/1ps
`include "hexio_macros.svh"
`default_nettype none

module hexio_top (
  input  wire                          clk_sys,
  input  wire                          rst_clk,
  input  wire hexio_chars_pkg::char_t  rx_char_i,
  input  wire                          rx_valid_i,
  output wire                          rx_credit_o,
  input  wire                          load_start_i,
  input  wire                          dump_start_i,
  output wire hexio_chars_pkg::char_t  tx_char_o,
  output wire                          tx_valid_o,
  input  wire                          tx_credit_i,
  output wire                          busy_o,
  output wire                          load_done_o
);

  // decode -> store
  logic                      sot_seen;
  logic                      word_valid;
  logic [`HEXIO_WORD_W-1:0]  word;
  // store <-> formatter
  logic [`HEXIO_ADDR_W-1:0]  rd_addr;
  logic [`HEXIO_WORD_W-1:0]  rd_word;
  logic                      dump_go;
  logic                      dump_done;

  hex_char_decode u_decode (
    .clk_sys      (clk_sys),
    .rst_clk      (rst_clk),
    .rx_char_i    (rx_char_i),
    .rx_valid_i   (rx_valid_i),
    .rx_credit_o  (rx_credit_o),
    .sot_seen_o   (sot_seen),
    .word_valid_o (word_valid),
    .word_o       (word)
  );

  image_store u_store (
    .clk_sys      (clk_sys),
    .rst_clk      (rst_clk),
    .load_start_i (load_start_i),
    .dump_start_i (dump_start_i),
    .sot_seen_i   (sot_seen),
    .word_valid_i (word_valid),
    .word_i       (word),
    .rd_addr_i    (rd_addr),
    .dump_done_i  (dump_done),
    .rd_word_o    (rd_word),
    .dump_go_o    (dump_go),
    .busy_o       (busy_o),
    .load_done_o  (load_done_o)
  );

  dump_formatter u_format (
    .clk_sys      (clk_sys),
    .rst_clk      (rst_clk),
    .dump_go_i    (dump_go),
    .rd_word_i    (rd_word),
    .tx_credit_i  (tx_credit_i),
    .rd_addr_o    (rd_addr),
    .tx_char_o    (tx_char_o),
    .tx_valid_o   (tx_valid_o),
    .dump_done_o  (dump_done)
  );

endmodule

`default_nettype wire

// File: tests/hexio_checker.sv
// watches the transmit stream and the pulse outputs of hexio_top
// expected characters are indexed by seen_o, so the source must follow that count
`timescale 1ns/1ps
`default_nettype none

module hexio_checker (
  input  wire        clk_sys,
  input  wire        rst_clk,
  input  wire [7:0]  tx_char_i,
  input  wire        tx_valid_i,
  input  wire        rx_credit_i,
  input  wire        load_done_i,
  input  wire        busy_i,
  input  wire [7:0]  exp_char_i,   // expected char at index seen_o
  input  wire [31:0] exp_len_i,    // chars expected so far
  input  wire        final_i,      // one pulse, compares the counts
  input  wire [31:0] exp_rx_i,
  input  wire [31:0] exp_load_i,
  output logic [31:0] seen_o,
  output logic [31:0] errors_o
);

  logic [31:0] rx_cnt;      // credit pulses seen
  logic [31:0] load_cnt;    // load_done pulses seen
  int unsigned cycle_errs;  // mismatches found on this edge

  // ***********************************************************
  // transmit stream compare
  // ***********************************************************
  always @(posedge clk_sys)
  begin
    cycle_errs = 0;
    if (rst_clk)
    begin
      seen_o   <= '0;
      errors_o <= '0;
      rx_cnt   <= '0;
      load_cnt <= '0;
    end
    else
    begin
      if (rx_credit_i)
        rx_cnt <= rx_cnt + 1;
      if (load_done_i)
        load_cnt <= load_cnt + 1;
      if (tx_valid_i)
      begin
        seen_o <= seen_o + 1;
        if (seen_o >= exp_len_i)
        begin
          $display("[ERROR] %0t unexpected character %02h on tx_char_o beyond the dump",
                   $time, tx_char_i);
          cycle_errs = cycle_errs + 1;
        end
        else if (tx_char_i !== exp_char_i)
        begin
          $display("[ERROR] %0t tx_char_o expected %02h got %02h",
                   $time, exp_char_i, tx_char_i);
          cycle_errs = cycle_errs + 1;
        end
      end
      // a dump runs outside IDLE
      if (tx_valid_i && (busy_i !== 1'b1))
      begin
        $display("[ERROR] %0t busy_o expected 1 got %b while tx_valid_o is high",
                 $time, busy_i);
        cycle_errs = cycle_errs + 1;
      end
      // load has finished, back in IDLE
      if (load_done_i && (busy_i !== 1'b0))
      begin
        $display("[ERROR] %0t busy_o expected 0 got %b on load_done_o",
                 $time, busy_i);
        cycle_errs = cycle_errs + 1;
      end
      if (final_i)
      begin
        // counts at end of run
        if (rx_cnt != exp_rx_i)
        begin
          $display("[ERROR] %0t rx_credit_o pulses expected %0d got %0d",
                   $time, exp_rx_i, rx_cnt);
          cycle_errs = cycle_errs + 1;
        end
        if (load_cnt != exp_load_i)
        begin
          $display("[ERROR] %0t load_done_o pulses expected %0d got %0d",
                   $time, exp_load_i, load_cnt);
          cycle_errs = cycle_errs + 1;
        end
      end
      errors_o <= errors_o + cycle_errs;
    end
  end

endmodule

`default_nettype wire

// File: tests/hexio_sva.sv
// credit and reset rules of hexio_top, bound into every instance
`timescale 1ns/1ps
`include "hexio_macros.svh"
`default_nettype none

module hexio_sva (
  input wire        clk_sys,
  input wire        rst_clk,
  input wire        rx_valid_i,
  input wire        rx_full_i,     // decode buffer full
  input wire        rx_credit_o,
  input wire        tx_valid_o,
  input wire        tx_credit_i,
  input wire        busy_o,
  input wire        load_done_o,
  input wire        dump_done_i
);

  int unsigned tx_owed;   // chars sent minus credits returned

  always @(posedge clk_sys)
  begin
    if (rst_clk)
      tx_owed <= 0;
    else
      tx_owed <= tx_owed + (tx_valid_o ? 1 : 0) - (tx_credit_i ? 1 : 0);
  end

  // sender never hits a full buffer
  a_rx_no_overrun: assert property (@(posedge clk_sys) disable iff (rst_clk)
    rx_valid_i |-> !rx_full_i)
    else $error("receive character arrived with the buffer full");

  // no more chars in flight than credits granted
  a_tx_credit_bound: assert property (@(posedge clk_sys) disable iff (rst_clk)
    tx_owed <= `HEXIO_TX_CREDITS)
    else $error("transmit characters exceed granted credits");

  a_reset_values: assert property (@(posedge clk_sys)
    rst_clk |=> (!tx_valid_o && !rx_credit_o && !busy_o && !load_done_o && !dump_done_i))
    else $error("outputs not at reset values after reset");

endmodule

bind hexio_top hexio_sva u_sva (
  .clk_sys     (clk_sys),
  .rst_clk     (rst_clk),
  .rx_valid_i  (rx_valid_i),
  .rx_full_i   (u_decode.fill_cnt == `HEXIO_RX_CREDITS),
  .rx_credit_o (rx_credit_o),
  .tx_valid_o  (tx_valid_o),
  .tx_credit_i (tx_credit_i),
  .busy_o      (busy_o),
  .load_done_o (load_done_o),
  .dump_done_i (u_format.dump_done_o)
);

`default_nettype wire

// File: tests/hexio_tb.sv
// load/dump round trips of hexio_top with credit flow on both streams
// inputs change on the falling edge, the checker samples on the rising edge
`timescale 1ns/1ps
`include "hexio_macros.svh"
`default_nettype none

module hexio_tb;

  import hexio_chars_pkg::*;

  localparam int SEED       = 23122;
  localparam int RST_CYCLES = 8;
  localparam int DUMP_CHARS = 3 + `HEXIO_DEPTH * (`HEXIO_NIBBLES + 2) + 1;
  localparam int RX_CHARS   = 4 * (12 + `HEXIO_DEPTH * `HEXIO_NIBBLES * 2);
  localparam int CREDIT_MARGIN = 8;                      // slow credit returns
  localparam int TIMEOUT_CYCLES = (2 * RX_CHARS + 4 * DUMP_CHARS) * CREDIT_MARGIN;

  logic clk_sys;
  logic rst_clk;
  char_t rx_char;
  logic rx_valid, load_start, dump_start, tx_credit;
  char_t tx_char;
  logic rx_credit, tx_valid, busy, load_done;

  logic [`HEXIO_WORD_W-1:0] image [`HEXIO_DEPTH];  // model of the memory
  logic [`HEXIO_WORD_W-1:0] words [`HEXIO_DEPTH];  // next stream to send
  char_t exp_mem [0:1023];
  int    exp_len, sent_cnt, ret_cnt, load_cnt;
  int    tx_spent, tx_given, credit_rate, cycles;
  logic  final_chk;
  logic [31:0] seen, chk_errors;
  char_t exp_char;

  assign exp_char = (seen < exp_len) ? exp_mem[seen] : 8'h00;

  hexio_top DUT (
    .clk_sys(clk_sys), .rst_clk(rst_clk),
    .rx_char_i(rx_char), .rx_valid_i(rx_valid), .rx_credit_o(rx_credit),
    .load_start_i(load_start), .dump_start_i(dump_start),
    .tx_char_o(tx_char), .tx_valid_o(tx_valid), .tx_credit_i(tx_credit),
    .busy_o(busy), .load_done_o(load_done)
  );

  hexio_checker u_checker (
    .clk_sys(clk_sys), .rst_clk(rst_clk),
    .tx_char_i(tx_char), .tx_valid_i(tx_valid), .rx_credit_i(rx_credit),
    .load_done_i(load_done), .busy_i(busy),
    .exp_char_i(exp_char), .exp_len_i(exp_len),
    .final_i(final_chk), .exp_rx_i(sent_cnt), .exp_load_i(load_cnt),
    .seen_o(seen), .errors_o(chk_errors)
  );

  // ***********************************************************
  // reference and helpers
  // ***********************************************************
  function automatic char_t digit_char(input logic [3:0] n, input bit upper);
    if (n < 10)
      return 8'h30 + 8'(n);
    return (upper ? 8'h41 : 8'h61) + 8'(n) - 8'd10;
  endfunction

  // k-th character of a dump of image
  function automatic char_t dump_char(input int k);
    int row;
    int col;
    if (k == 0) return 8'h01;
    if (k == 1) return 8'h03;
    if (k == 2) return 8'h02;
    if (k == DUMP_CHARS - 1) return 8'h04;
    row = (k - 3) / (`HEXIO_NIBBLES + 2);
    col = (k - 3) % (`HEXIO_NIBBLES + 2);
    if (col == `HEXIO_NIBBLES) return 8'h0D;
    if (col == `HEXIO_NIBBLES + 1) return 8'h0A;
    return digit_char(image[row][`HEXIO_WORD_W-1-4*col -: 4], 1'b1);
  endfunction

  initial
  begin
    clk_sys = 1'b0;
    forever #10 clk_sys = ~clk_sys;   // 20 ns
  end

  always @(posedge clk_sys)
  begin
    cycles <= cycles + 1;
    if (rx_credit) ret_cnt <= ret_cnt + 1;
    if (tx_valid) tx_spent <= tx_spent + 1;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // transmit credits back after a random delay
  always @(negedge clk_sys)
  begin
    tx_credit <= 1'b0;
    if ((tx_given < tx_spent) && (($urandom % 100) < credit_rate))
    begin
      tx_credit <= 1'b1;
      tx_given  <= tx_given + 1;
    end
  end

  task automatic send_char(input char_t c);
    @(negedge clk_sys);
    while (sent_cnt - ret_cnt >= `HEXIO_RX_CREDITS)   // out of credits
      @(negedge clk_sys);
    rx_char  = c;
    rx_valid = 1'b1;
    sent_cnt = sent_cnt + 1;
    @(negedge clk_sys);
    rx_valid = 1'b0;
  endtask

  task automatic send_words(input bit mixed);
    char_t sep [4];
    sep = '{8'h20, 8'h2C, 8'h0D, 8'h0A};
    for (int w = 0; w < `HEXIO_DEPTH; w++)
      for (int i = 0; i < `HEXIO_NIBBLES; i++)
      begin
        send_char(digit_char(words[w][`HEXIO_WORD_W-1-4*i -: 4],
                             mixed ? 1'($urandom % 2) : 1'b1));
        if (mixed && ($urandom % 3 == 0))
          send_char(sep[$urandom % 4]);
      end
  endtask

  task automatic new_words();
    for (int w = 0; w < `HEXIO_DEPTH; w++)
      words[w] = $urandom;
  endtask

  // one-cycle load or dump command
  task automatic pulse_command(input bit load);
    @(negedge clk_sys);
    if (load)
      load_start = 1'b1;
    else
      dump_start = 1'b1;
    @(negedge clk_sys);
    load_start = 1'b0;
    dump_start = 1'b0;
  endtask

  task automatic load_image(input bit mixed, input bit junk);
    pulse_command(1'b1);
    if (junk)
      for (int i = 0; i < 11; i++)
        send_char(digit_char(4'($urandom), 1'b1));   // before SOT, ignored
    send_char(8'h02);
    send_words(mixed);
    while (busy) @(negedge clk_sys);
    @(negedge clk_sys);
    load_cnt = load_cnt + 1;
    for (int w = 0; w < `HEXIO_DEPTH; w++)
      image[w] = words[w];
  endtask

  task automatic dump_image(input int rate);
    credit_rate = rate;
    for (int k = 0; k < DUMP_CHARS; k++)
      exp_mem[exp_len + k] = dump_char(k);
    exp_len = exp_len + DUMP_CHARS;
    pulse_command(1'b0);
    while (busy || (seen < exp_len)) @(negedge clk_sys);
  endtask

  // ***********************************************************
  // test sequence
  // ***********************************************************
  initial
  begin
    void'($urandom(SEED));
    rst_clk = 1'b1;
    rx_char = 8'h00;
    {rx_valid, load_start, dump_start, tx_credit, final_chk} = '0;
    {exp_len, sent_cnt, ret_cnt, load_cnt, tx_spent, tx_given, cycles} = '0;
    credit_rate = 100;
    repeat (RST_CYCLES) @(negedge clk_sys);
    rst_clk = 1'b0;

    // round trip
    new_words();
    load_image(1'b0, 1'b0);
    dump_image(100);
    // mixed case, separators
    new_words();
    load_image(1'b1, 1'b0);
    dump_image(100);
    // junk before SOT
    new_words();
    load_image(1'b0, 1'b1);
    // stream with no load
    new_words();
    send_char(8'h02);
    send_words(1'b0);
    while (ret_cnt != sent_cnt) @(negedge clk_sys);
    dump_image(100);
    dump_image(20);                                         // starved credits

    @(negedge clk_sys);
    final_chk = 1'b1;
    @(negedge clk_sys);
    final_chk = 1'b0;
    @(negedge clk_sys);
    $display("errors: %0d, characters checked: %0d", chk_errors, seen);
    if (chk_errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: hexio_top.f
+incdir+hw
hw/hexio_chars_pkg.sv
hw/hexio_ctrl_pkg.sv
hw/hex_char_decode.sv
hw/image_store.sv
hw/dump_formatter.sv
hw/hexio_top.sv
tests/hexio_checker.sv
tests/hexio_sva.sv
tests/hexio_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= hexio_tb
FILELIST  ?= hexio_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
